// File: flist.f
rtl/soc_cfg_pkg.sv
rtl/soc_map_pkg.sv
rtl/req_capture.sv
rtl/region_matcher.sv
rtl/port_select.sv
rtl/debug_req_gate.sv
rtl/soc_addr_decoder.sv
sim/soc_addr_decoder_tb.sv

// File: sim/soc_addr_decoder_tb.sv
// Testbench for the subsystem address decoder and the debug request hold-off
module soc_addr_decoder_tb;

  localparam int ResetCycles  = 3;
  localparam int TableLen     = 36;
  localparam int RandReqs     = 200;
  localparam int MaxGap       = 3;
  localparam int DbgRandCount = 32;
  localparam int Margin       = 64;
  localparam int TimeoutCycles = ResetCycles + soc_cfg_pkg::DmiDelCycles + TableLen
                                 + RandReqs * (MaxGap + 1) + DbgRandCount + Margin;

  // --------------------------------------------------------------------------
  // Address table: start, middle, last and first-past-end of each region
  // --------------------------------------------------------------------------
  localparam logic [63:0] TblAddr [TableLen] = '{
    64'h0,          64'h800,        64'hFFF,        64'h1000,
    64'h1_0000,     64'h1_8000,     64'h1_FFFF,     64'h2_0000,
    64'h200_0000,   64'h206_0000,   64'h20B_FFFF,   64'h20C_0000,
    64'hC00_0000,   64'hE00_0000,   64'hFFF_FFFF,   64'h1000_0000,
    64'h1C00_0000,  64'h1C04_0000,  64'h1C07_FFFF,  64'h1C08_0000,
    64'h1A10_0000,  64'h1A18_0000,  64'h1A1F_FFFF,  64'h1A20_0000,
    64'h8000_0000,  64'hA000_0000,  64'hBFFF_FFFF,  64'hC000_0000,
    64'h7000_0000,  64'h7001_0000,  64'h7001_FFFF,  64'h7002_0000,
    64'h8000,       64'h3000_0000,  64'h1_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF
  };
  localparam logic [2:0] TblPort [TableLen] = '{
    3'd0, 3'd0, 3'd0, 3'd0,  3'd1, 3'd1, 3'd1, 3'd0,  3'd2, 3'd2, 3'd2, 3'd0,
    3'd3, 3'd3, 3'd3, 3'd0,  3'd4, 3'd4, 3'd4, 3'd0,  3'd5, 3'd5, 3'd5, 3'd0,
    3'd6, 3'd6, 3'd6, 3'd0,  3'd6, 3'd6, 3'd6, 3'd0,  3'd0, 3'd0, 3'd0, 3'd0
  };
  localparam bit TblErr [TableLen] = '{
    0, 0, 0, 1,  0, 0, 0, 1,  0, 0, 0, 1,  0, 0, 0, 1,  0, 0, 0, 1,  0, 0, 0, 1,
    0, 0, 0, 1,  0, 0, 0, 1,  1, 1, 1, 1
  };

  logic                                 clk_i;
  logic                                 ndmreset_n;
  logic                                 req_i;
  logic [soc_cfg_pkg::AddrWidth-1:0]    addr_i;
  logic                                 valid_o;
  logic [soc_map_pkg::PortIdxWidth-1:0] port_o;
  logic                                 decerr_o;
  logic [soc_cfg_pkg::NumHarts-1:0]     debug_req_i;
  logic [soc_cfg_pkg::NumHarts-1:0]     debug_req_o;

  // Expected result that travels with each request
  logic [soc_map_pkg::PortIdxWidth-1:0] exp_port_d;
  logic                                 exp_err_d;

  int   due_q[$];
  logic [2:0] port_q[$];
  bit   err_q[$];
  int   cyc;
  bit   expect_now;

  soc_addr_decoder soc_addr_decoder_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .addr_i      ( addr_i      ),
    .valid_o     ( valid_o     ),
    .port_o      ( port_o      ),
    .decerr_o    ( decerr_o    ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Reference decode, lowest matching rule wins, no match is a decode error
  function automatic logic [3:0] decode_ref(input logic [63:0] addr);
    logic [3:0] res;
    bit         found;
    res   = 4'b1000;
    found = 1'b0;
    for (int r = 0; r < soc_map_pkg::NumRules; r++) begin
      if (!found && addr >= soc_map_pkg::RuleStart[r] && addr < soc_map_pkg::RuleEnd[r]) begin
        res   = {1'b0, soc_map_pkg::RulePort[r]};
        found = 1'b1;
      end
    end
    return res;
  endfunction

  // --------------------------------------------------------------------------
  // Response monitor, samples on the falling edge
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    cyc = cyc + 1;
    if (cyc > TimeoutCycles) begin
      abort_run("Timeout: the run went past its cycle limit");
    end else if (ndmreset_n) begin
      // Request seen here comes out three falling edges later
      if (req_i) begin
        due_q.push_back(cyc + 3);
        port_q.push_back(exp_port_d);
        err_q.push_back(exp_err_d);
      end
      expect_now = (due_q.size() != 0) && (due_q[0] == cyc);
      if (valid_o && !expect_now) begin
        abort_run("valid_o went high with no request outstanding for it");
      end else if (!valid_o && expect_now) begin
        abort_run("valid_o missing for a request three edges after it was taken");
      end else if (valid_o) begin
        check("port_o", port_o, port_q[0]);
        check("decerr_o", decerr_o, err_q[0]);
        void'(due_q.pop_front());
        void'(port_q.pop_front());
        void'(err_q.pop_front());
      end else begin
        check("port_o", port_o, 0);
        check("decerr_o", decerr_o, 0);
      end
    end
  end

  initial begin
    int unsigned         seed;
    int unsigned         sel;
    int unsigned         gap;
    logic [63:0]         addr;
    logic [63:0]         span;
    logic [3:0]          exp;
    seed        = 32'hc936e78d;
    void'($urandom(seed));
    cyc         = 0;
    ndmreset_n  = 1'b0;
    req_i       = 1'b0;
    addr_i      = '0;
    debug_req_i = '1;
    exp_port_d  = '0;
    exp_err_d   = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // Hold-off window, nothing may come out before a request either
    for (int i = 0; i < soc_cfg_pkg::DmiDelCycles; i++) begin
      @(negedge clk_i);
      check("debug_req_o", debug_req_o, 0);
      check("valid_o", valid_o, 0);
      check("decerr_o", decerr_o, 0);
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check("debug_req_o", debug_req_o, debug_req_i);

    // Gate now open, output follows the input in the same cycle
    for (int i = 0; i < DbgRandCount; i++) begin
      @(posedge clk_i);
      debug_req_i <= $urandom;
      @(negedge clk_i);
      check("debug_req_o", debug_req_o, debug_req_i);
    end

    // Table, one request per cycle
    for (int i = 0; i < TableLen; i++) begin
      @(posedge clk_i);
      req_i      <= 1'b1;
      addr_i     <= TblAddr[i];
      exp_port_d <= TblPort[i];
      exp_err_d  <= TblErr[i];
    end

    // Random addresses, mostly around region edges, with random gaps
    for (int n = 0; n < RandReqs; n++) begin
      sel = $urandom_range(0, soc_map_pkg::NumRules + 1);
      if (sel < soc_map_pkg::NumRules) begin
        span = soc_map_pkg::RuleEnd[sel] - soc_map_pkg::RuleStart[sel] + 64'd32;
        addr = soc_map_pkg::RuleStart[sel] - 64'd16 + ({32'h0, $urandom} % span);
      end else begin
        addr = {$urandom, $urandom};
      end
      exp = decode_ref(addr);
      gap = $urandom_range(0, MaxGap);
      @(posedge clk_i);
      req_i      <= 1'b1;
      addr_i     <= addr;
      exp_port_d <= exp[2:0];
      exp_err_d  <= exp[3];
      if (gap > 0) begin
        @(posedge clk_i);
        req_i <= 1'b0;
        repeat (gap - 1) @(posedge clk_i);
      end
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (due_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);

    $display("** PASS **");
    $finish;
  end

endmodule

// File: rtl/soc_addr_decoder.sv
// Subsystem address decoder with debug request hold-off, top level
module soc_addr_decoder (
  input  logic                                 clk_i,
  input  logic                                 ndmreset_n,
  input  logic                                 req_i,
  input  logic [soc_cfg_pkg::AddrWidth-1:0]    addr_i,
  output logic                                 valid_o,
  output logic [soc_map_pkg::PortIdxWidth-1:0] port_o,
  output logic                                 decerr_o,
  input  logic [soc_cfg_pkg::NumHarts-1:0]     debug_req_i,
  output logic [soc_cfg_pkg::NumHarts-1:0]     debug_req_o
);

  logic                                                           cap_valid;
  logic [soc_cfg_pkg::AddrWidth-1:0]                              cap_addr;
  logic [soc_map_pkg::NumRules-1:0]                               rule_valid;
  logic [soc_map_pkg::NumRules-1:0]                               rule_hit;
  logic [soc_map_pkg::NumRules-1:0][soc_map_pkg::PortIdxWidth-1:0] rule_port;

  // --------------------------------------------------------------------------
  // Request capture
  // --------------------------------------------------------------------------
  req_capture req_capture_i (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .req_i       ( req_i      ),
    .addr_i      ( addr_i     ),
    .cap_valid_o ( cap_valid  ),
    .cap_addr_o  ( cap_addr   )
  );

  // --------------------------------------------------------------------------
  // Rule matchers
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < soc_map_pkg::NumRules; g++) begin : g_rule
    region_matcher region_matcher_i (
      .clk_i         ( clk_i         ),
      .ndmreset_n    ( ndmreset_n    ),
      .rule_idx_i    ( g             ),
      .cap_valid_i   ( cap_valid     ),
      .cap_addr_i    ( cap_addr      ),
      .match_valid_o ( rule_valid[g] ),
      .hit_o         ( rule_hit[g]   ),
      .port_o        ( rule_port[g]  )
    );
  end

  // --------------------------------------------------------------------------
  // Port select
  // --------------------------------------------------------------------------
  // All matchers register the same valid, rule 0 carries it on
  port_select port_select_i (
    .clk_i         ( clk_i         ),
    .ndmreset_n    ( ndmreset_n    ),
    .match_valid_i ( rule_valid[0] ),
    .hit_i         ( rule_hit      ),
    .port_i        ( rule_port     ),
    .valid_o       ( valid_o       ),
    .decerr_o      ( decerr_o      ),
    .port_o        ( port_o        )
  );

  // --------------------------------------------------------------------------
  // Debug request hold-off
  // --------------------------------------------------------------------------
  debug_req_gate debug_req_gate_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: rtl/debug_req_gate.sv
// Holds hart debug requests off for a fixed number of cycles after reset
module debug_req_gate (
  input  logic                             clk_i,
  input  logic                             ndmreset_n,
  input  logic [soc_cfg_pkg::NumHarts-1:0] debug_req_i,
  output logic [soc_cfg_pkg::NumHarts-1:0] debug_req_o
);

  logic [soc_cfg_pkg::DelCntWidth-1:0] del_cnt_d;
  logic [soc_cfg_pkg::DelCntWidth-1:0] del_cnt_q;
  logic                                holdoff;

  assign holdoff = (del_cnt_q != '0);

  // --------------------------------------------------------------------------
  // Hold-off counter
  // --------------------------------------------------------------------------
  // Counts down once and then parks at zero until the next reset
  assign del_cnt_d = holdoff ? del_cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      del_cnt_q <= soc_cfg_pkg::DelCntInit;
    end else begin
      del_cnt_q <= del_cnt_d;
    end
  end

  // Passes straight through once expired, no added latency
  assign debug_req_o = holdoff ? '0 : debug_req_i;

  a_gated_while_counting : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    holdoff |-> (debug_req_o == '0)
  ) else $error("debug_req_gate: debug request leaked during hold-off");

endmodule

// File: rtl/port_select.sv
// Priority select over the rule hits, registers port index, valid and decode error
module port_select (
  input  logic                                                        clk_i,
  input  logic                                                        ndmreset_n,
  input  logic                                                        match_valid_i,
  input  logic [soc_map_pkg::NumRules-1:0]                            hit_i,
  input  logic [soc_map_pkg::NumRules-1:0][soc_map_pkg::PortIdxWidth-1:0] port_i,
  output logic                                                        valid_o,
  output logic                                                        decerr_o,
  output logic [soc_map_pkg::PortIdxWidth-1:0]                        port_o
);

  logic                                any_hit;
  logic [soc_map_pkg::PortIdxWidth-1:0] sel_port;

  assign any_hit = |hit_i;

  // --------------------------------------------------------------------------
  // Priority encode
  // --------------------------------------------------------------------------
  // Walk down so the lowest-numbered hit is the one that sticks
  always_comb begin
    sel_port = '0;
    for (int i = soc_map_pkg::NumRules - 1; i >= 0; i--) begin
      if (hit_i[i]) begin
        sel_port = port_i[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Output stage
  // --------------------------------------------------------------------------
  // Default port is disabled, a miss becomes a decode error on port 0
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_o  <= 1'b0;
      decerr_o <= 1'b0;
      port_o   <= '0;
    end else begin
      valid_o  <= match_valid_i;
      decerr_o <= match_valid_i && !any_hit;
      if (match_valid_i && any_hit) begin
        port_o <= sel_port;
      end else begin
        port_o <= '0;
      end
    end
  end

  // The map has no overlapping windows, so the priority never has to act
  a_hits_onehot : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0(hit_i)
  ) else $error("port_select: more than one address rule hit");

endmodule

// File: rtl/region_matcher.sv
// One address rule of the map, registers a hit on its window and the rule's port
module region_matcher (
  input  logic                                  clk_i,
  input  logic                                  ndmreset_n,
  input  int unsigned                           rule_idx_i,
  input  logic                                  cap_valid_i,
  input  logic [soc_cfg_pkg::AddrWidth-1:0]     cap_addr_i,
  output logic                                  match_valid_o,
  output logic                                  hit_o,
  output logic [soc_map_pkg::PortIdxWidth-1:0]  port_o
);

  logic [soc_cfg_pkg::AddrWidth-1:0] rule_start;
  logic [soc_cfg_pkg::AddrWidth-1:0] rule_end;
  logic                              in_window;

  // Rule index is tied at the instance, so this folds to constants
  assign rule_start = soc_map_pkg::RuleStart[rule_idx_i];
  assign rule_end   = soc_map_pkg::RuleEnd[rule_idx_i];

  // End is exclusive
  assign in_window = (cap_addr_i >= rule_start) && (cap_addr_i < rule_end);

  // --------------------------------------------------------------------------
  // Match stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      match_valid_o <= 1'b0;
      hit_o         <= 1'b0;
    end else begin
      match_valid_o <= cap_valid_i;
      hit_o         <= cap_valid_i && in_window;
    end
  end

  // Port travels with the request, only read when the hit is set
  always_ff @(posedge clk_i) begin
    if (cap_valid_i) begin
      port_o <= soc_map_pkg::RulePort[rule_idx_i];
    end
  end

  // Empty or inverted windows in the map are caught at elaboration
  for (genvar r = 0; r < soc_map_pkg::NumRules; r++) begin : g_rule_check
    if (soc_map_pkg::RuleStart[r] >= soc_map_pkg::RuleEnd[r]) begin : g_bad_rule
      $error("region_matcher: rule %0d start is not below its end", r);
    end
  end

endmodule

// File: rtl/req_capture.sv
// Request input stage, registers the address strobe and its address
module req_capture (
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                req_i,
  input  logic [soc_cfg_pkg::AddrWidth-1:0]   addr_i,
  output logic                                cap_valid_o,
  output logic [soc_cfg_pkg::AddrWidth-1:0]   cap_addr_o
);

  // --------------------------------------------------------------------------
  // Strobe register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cap_valid_o <= 1'b0;
    end else begin
      cap_valid_o <= req_i;
    end
  end

  // --------------------------------------------------------------------------
  // Address register
  // --------------------------------------------------------------------------
  // Holds the last request between strobes
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      cap_addr_o <= addr_i;
    end
  end

  // An unknown address would turn into an unknown hit downstream
  a_addr_known : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    req_i |-> !$isunknown(addr_i)
  ) else $error("req_capture: address unknown while req_i is high");

endmodule

// File: rtl/soc_map_pkg.sv
// Crossbar address map: port indices, region windows and the rule table
package soc_map_pkg;

  // --------------------------------------------------------------------------
  // Target ports
  // --------------------------------------------------------------------------
  localparam int unsigned NumPorts     = 7;
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);

  localparam logic [PortIdxWidth-1:0] PortDebug = 3'd0;
  localparam logic [PortIdxWidth-1:0] PortRom   = 3'd1;
  localparam logic [PortIdxWidth-1:0] PortClint = 3'd2;
  localparam logic [PortIdxWidth-1:0] PortPlic  = 3'd3;
  localparam logic [PortIdxWidth-1:0] PortL2spm = 3'd4;
  localparam logic [PortIdxWidth-1:0] PortApb   = 3'd5;
  localparam logic [PortIdxWidth-1:0] PortHyaxi = 3'd6;

  // One rule per port, plus the LLC scratchpad alias onto HyperBus
  localparam int unsigned NumRules = NumPorts + 1;

  // --------------------------------------------------------------------------
  // Region bases
  // --------------------------------------------------------------------------
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] DebugBase  = 64'h0000_0000_0000_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] RomBase    = 64'h0000_0000_0001_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] ClintBase  = 64'h0000_0000_0200_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] PlicBase   = 64'h0000_0000_0C00_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] ApbBase    = 64'h0000_0000_1A10_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] L2spmBase  = 64'h0000_0000_1C00_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] LlcspmBase = 64'h0000_0000_7000_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] HyaxiBase  = 64'h0000_0000_8000_0000;

  // --------------------------------------------------------------------------
  // Region lengths
  // --------------------------------------------------------------------------
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] DebugLength  = 64'h0000_1000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] RomLength    = 64'h0001_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] ClintLength  = 64'h000C_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] PlicLength   = 64'h0400_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] ApbLength    = 64'h0010_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] L2spmLength  = 64'h0008_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] LlcspmLength = 64'h0002_0000;
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] HyaxiLength  = 64'h4000_0000;

  // --------------------------------------------------------------------------
  // Rule table, windows are [start, end)
  // --------------------------------------------------------------------------
  localparam logic [soc_cfg_pkg::AddrWidth-1:0] RuleStart [NumRules] = '{
    DebugBase, RomBase, ClintBase, PlicBase,
    L2spmBase, ApbBase, HyaxiBase, LlcspmBase
  };

  localparam logic [soc_cfg_pkg::AddrWidth-1:0] RuleEnd [NumRules] = '{
    DebugBase + DebugLength, RomBase + RomLength,
    ClintBase + ClintLength, PlicBase + PlicLength,
    L2spmBase + L2spmLength, ApbBase + ApbLength,
    HyaxiBase + HyaxiLength, LlcspmBase + LlcspmLength
  };

  // Last rule is the scratchpad alias, it shares the HyperBus port
  localparam logic [PortIdxWidth-1:0] RulePort [NumRules] = '{
    PortDebug, PortRom, PortClint, PortPlic,
    PortL2spm, PortApb, PortHyaxi, PortHyaxi
  };

endpackage

// File: rtl/soc_cfg_pkg.sv
// Subsystem configuration shared by the address decoder and the debug request gate
package soc_cfg_pkg;

  // --------------------------------------------------------------------------
  // Bus
  // --------------------------------------------------------------------------
  // Width of a bus address
  localparam int unsigned AddrWidth = 64;

  // --------------------------------------------------------------------------
  // Harts and debug
  // --------------------------------------------------------------------------
  // Harts that can receive a debug request
  localparam int unsigned NumHarts = 2;

  // Boot code gets this many cycles before a debug request can reach a hart,
  // so the first-stage loader can set up a0/a1 undisturbed
  localparam int unsigned DmiDelCycles = 500;

  // Hold-off counter must represent DmiDelCycles itself
  localparam int unsigned DelCntWidth = $clog2(DmiDelCycles + 1);

  // Counter value loaded while in reset
  localparam logic [DelCntWidth-1:0] DelCntInit = DmiDelCycles[DelCntWidth-1:0];

endpackage
